// File: hdl/lmfe_cfg_pkg.sv
package lmfe_cfg_pkg;

  // sample format
  localparam int SAMPLE_W = 8;

  typedef logic [SAMPLE_W-1:0] sample_t;

  // sliding window, median sits in the middle slot
  localparam int WIN         = 7;
  localparam int MEDIAN_RANK = 3;

  // samples between two flushes
  localparam int FRAME_LEN = 64;

  // one counter covers both the frame and the flush run
  localparam int COUNT_W = $clog2(FRAME_LEN);

  // fixed neighbours at both ends of the sorted chain
  localparam sample_t SAMPLE_MIN = '0;
  localparam sample_t SAMPLE_MAX = '1;

endpackage

// File: hdl/lmfe_ctrl_pkg.sv
package lmfe_ctrl_pkg;

  // RUN takes samples, FLUSH shifts zeros back in
  typedef enum logic {
    RUN   = 1'b0,
    FLUSH = 1'b1
  } ctrl_state_t;

endpackage

// File: hdl/rank_cell.sv
module rank_cell (
  input  logic                  CLK,
  input  logic                  RST,
  input  lmfe_cfg_pkg::sample_t ins,
  input  lmfe_cfg_pkg::sample_t del,
  input  lmfe_cfg_pkg::sample_t lower,
  input  lmfe_cfg_pkg::sample_t upper,
  output lmfe_cfg_pkg::sample_t value
);
  import lmfe_cfg_pkg::*;

  sample_t value_nxt;

  always_comb begin
    value_nxt = value;
    if (ins < del) begin
      // entries in (ins, del] move up one slot
      if (value > ins && value <= del) begin
        value_nxt = (lower > ins) ? lower : ins;
      end
    end else if (ins > del) begin
      // entries in [del, ins) move down one slot
      if (value < ins && value >= del) begin
        value_nxt = (upper < ins) ? upper : ins;
      end
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      value <= '0;
    end else begin
      value <= value_nxt;
    end
  end

endmodule

// File: hdl/rank_sorter.sv
module rank_sorter (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  update,
  input  lmfe_cfg_pkg::sample_t ins,
  input  lmfe_cfg_pkg::sample_t del,
  output lmfe_cfg_pkg::sample_t median
);
  import lmfe_cfg_pkg::*;

  sample_t ins_eff;
  sample_t del_eff;

  // chain[0] and chain[WIN+1] are the fixed ends,
  // chain[i+1] is the value of cell i
  wire sample_t chain [WIN+2];

  // equal pair when idle, no cell moves
  assign ins_eff = update ? ins : SAMPLE_MAX;
  assign del_eff = update ? del : SAMPLE_MAX;

  assign chain[0]     = SAMPLE_MIN;
  assign chain[WIN+1] = SAMPLE_MAX;

  for (genvar i = 0; i < WIN; i++) begin : g_cell
    rank_cell rank_cell_i (
      .CLK   (CLK),
      .RST   (RST),
      .ins   (ins_eff),
      .del   (del_eff),
      .lower (chain[i]),
      .upper (chain[i+2]),
      .value (chain[i+1])
    );
  end

  // middle of the sorted array
  assign median = chain[MEDIAN_RANK+1];

endmodule

// File: hdl/window_shift.sv
module window_shift (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  shift,
  input  lmfe_cfg_pkg::sample_t shift_in,
  output lmfe_cfg_pkg::sample_t oldest
);
  import lmfe_cfg_pkg::*;

  // taps[0] newest, taps[WIN-1] oldest
  sample_t taps [WIN];

  // sample about to drop out, seen before the shift
  assign oldest = taps[WIN-1];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      // start of run is zero padded
      for (int i = 0; i < WIN; i++) begin
        taps[i] <= '0;
      end
    end else if (shift) begin
      taps[0] <= shift_in;
      for (int i = 1; i < WIN; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

endmodule

// File: hdl/frame_counter.sv
module frame_counter (
  input  logic CLK,
  input  logic RST,
  input  logic accept,
  input  logic flush_step,
  output logic at_last,
  output logic flush_last
);
  import lmfe_cfg_pkg::*;

  logic [COUNT_W-1:0] count;
  logic               wrap;

  // position decodes only, the controller qualifies them
  assign at_last    = (count == COUNT_W'(FRAME_LEN - 1));
  assign flush_last = (count == COUNT_W'(WIN - 1));

  // end of frame or end of flush, start over from zero
  assign wrap = (accept && at_last) || (flush_step && flush_last);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      count <= '0;
    end else if (accept || flush_step) begin
      if (wrap) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

// File: hdl/median_ctrl.sv
module median_ctrl (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  in_en,
  input  lmfe_cfg_pkg::sample_t din,
  input  lmfe_cfg_pkg::sample_t oldest,
  input  lmfe_cfg_pkg::sample_t median,
  input  logic                  at_last,
  input  logic                  flush_last,
  output logic                  busy,
  output logic                  accept,
  output logic                  flush_step,
  output logic                  shift,
  output lmfe_cfg_pkg::sample_t shift_in,
  output logic                  update,
  output lmfe_cfg_pkg::sample_t ins,
  output lmfe_cfg_pkg::sample_t del,
  output logic                  out_valid,
  output lmfe_cfg_pkg::sample_t dout
);
  import lmfe_cfg_pkg::*;
  import lmfe_ctrl_pkg::*;

  ctrl_state_t state_r;
  ctrl_state_t state_nxt;

  // accept flag travelling alongside the sorter pipeline
  logic acc_q;
  logic acc_qq;

  // busy is the flush state itself
  assign busy       = (state_r == FLUSH);
  assign accept     = in_en && !busy;
  assign flush_step = (state_r == FLUSH);

  // window moves on a real sample or on a zero during flush
  assign shift    = accept || flush_step;
  assign shift_in = accept ? din : sample_t'(0);

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      RUN: begin
        // last sample of the frame starts the flush
        if (accept && at_last) begin
          state_nxt = FLUSH;
        end
      end
      FLUSH: begin
        if (flush_step && flush_last) begin
          state_nxt = RUN;
        end
      end
      default: begin
        state_nxt = RUN;
      end
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_r   <= RUN;
      update    <= 1'b0;
      acc_q     <= 1'b0;
      acc_qq    <= 1'b0;
      out_valid <= 1'b0;
      dout      <= '0;
    end else begin
      state_r   <= state_nxt;
      update    <= shift;
      acc_q     <= accept;
      acc_qq    <= acc_q;
      // sorter settled one edge after the pair, take it now
      out_valid <= acc_qq;
      if (acc_qq) begin
        dout <= median;
      end
    end
  end

  // insert/delete pair, the tail leaves as the new sample enters
  always_ff @(posedge CLK) begin
    if (shift) begin
      ins <= shift_in;
      del <= oldest;
    end
  end

endmodule

// File: hdl/lmfe_median.sv
module lmfe_median (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  in_en,
  input  lmfe_cfg_pkg::sample_t din,
  output logic                  busy,
  output logic                  out_valid,
  output lmfe_cfg_pkg::sample_t dout
);

  logic                  accept;
  logic                  flush_step;
  logic                  at_last;
  logic                  flush_last;
  logic                  shift;
  lmfe_cfg_pkg::sample_t shift_in;
  lmfe_cfg_pkg::sample_t oldest;
  logic                  update;
  lmfe_cfg_pkg::sample_t ins;
  lmfe_cfg_pkg::sample_t del;
  lmfe_cfg_pkg::sample_t median;

  median_ctrl median_ctrl_i (
    .CLK        (CLK),
    .RST        (RST),
    .in_en      (in_en),
    .din        (din),
    .oldest     (oldest),
    .median     (median),
    .at_last    (at_last),
    .flush_last (flush_last),
    .busy       (busy),
    .accept     (accept),
    .flush_step (flush_step),
    .shift      (shift),
    .shift_in   (shift_in),
    .update     (update),
    .ins        (ins),
    .del        (del),
    .out_valid  (out_valid),
    .dout       (dout)
  );

  frame_counter frame_counter_i (
    .CLK        (CLK),
    .RST        (RST),
    .accept     (accept),
    .flush_step (flush_step),
    .at_last    (at_last),
    .flush_last (flush_last)
  );

  window_shift window_shift_i (
    .CLK      (CLK),
    .RST      (RST),
    .shift    (shift),
    .shift_in (shift_in),
    .oldest   (oldest)
  );

  rank_sorter rank_sorter_i (
    .CLK    (CLK),
    .RST    (RST),
    .update (update),
    .ins    (ins),
    .del    (del),
    .median (median)
  );

endmodule

// File: bench/lmfe_median_sva.sv
module lmfe_median_sva (
  input logic                  CLK,
  input logic                  RST,
  input logic                  in_en,
  input logic                  busy,
  input logic                  out_valid,
  input lmfe_cfg_pkg::sample_t dout
);
  import lmfe_cfg_pkg::*;

  // number of failed assertions, watched from the testbench
  int unsigned fail_count = 0;

  logic accepted;

  // a sample enters on an edge with in_en high and busy low
  assign accepted = in_en && !busy;

  // result registered two edges after the accepting one,
  // so it is sampled on the third edge
  a_valid_after_accept : assert property (
    @(posedge CLK) disable iff (RST)
    accepted |-> ##3 out_valid
  ) else begin
    $error("out_valid missing two cycles after an accepted sample");
    fail_count++;
  end

  // no result without a sample behind it
  a_no_stray_valid : assert property (
    @(posedge CLK) disable iff (RST)
    out_valid |-> $past(accepted, 3)
  ) else begin
    $error("out_valid without an accepted sample two cycles before");
    fail_count++;
  end

  // flush window is WIN cycles long
  a_busy_length : assert property (
    @(posedge CLK) disable iff (RST)
    $rose(busy) |-> busy [*WIN] ##1 !busy
  ) else begin
    $error("busy did not stay high for exactly WIN cycles");
    fail_count++;
  end

  // quiet outputs while reset has been held since the previous edge
  a_reset_outputs : assert property (
    @(posedge CLK)
    (RST && $past(RST)) |-> (!busy && !out_valid && dout == '0)
  ) else begin
    $error("outputs not cleared during reset");
    fail_count++;
  end

endmodule

bind lmfe_median lmfe_median_sva lmfe_median_sva_i (
  .CLK       (CLK),
  .RST       (RST),
  .in_en     (in_en),
  .busy      (busy),
  .out_valid (out_valid),
  .dout      (dout)
);

// File: bench/lmfe_median_tb.sv
module lmfe_median_tb;
  import lmfe_cfg_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_FRAMES   = 3;
  // allowance for idle cycles of the gapped stream, per frame
  localparam int IDLE_GAPS    = FRAME_LEN;
  localparam int WATCHDOG_TIME =
    (NUM_FRAMES * (FRAME_LEN + WIN + IDLE_GAPS) + RESET_CYCLES) * CLK_PERIOD * 2;

  logic    CLK;
  logic    RST;
  logic    in_en;
  sample_t din;
  logic    busy;
  logic    out_valid;
  sample_t dout;

  integer  seed;
  // model window, history[0] newest
  sample_t history [WIN];
  sample_t expected_q [$];
  int      frame_count;
  int      flush_left;

  lmfe_median lmfe_median_i (
    .CLK       (CLK),
    .RST       (RST),
    .in_en     (in_en),
    .din       (din),
    .busy      (busy),
    .out_valid (out_valid),
    .dout      (dout)
  );

  initial CLK = 1'b0;

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic sample_t window_median();
    sample_t sorted [WIN];
    sample_t tmp;
    for (int i = 0; i < WIN; i++) begin
      sorted[i] = history[i];
    end
    // bubble sort, ascending
    for (int i = 0; i < WIN - 1; i++) begin
      for (int j = 0; j < WIN - 1 - i; j++) begin
        if (sorted[j] > sorted[j+1]) begin
          tmp         = sorted[j];
          sorted[j]   = sorted[j+1];
          sorted[j+1] = tmp;
        end
      end
    end
    return sorted[MEDIAN_RANK];
  endfunction

  task automatic clear_history();
    for (int i = 0; i < WIN; i++) begin
      history[i] = '0;
    end
  endtask

  // one accepted sample enters the model window
  task automatic record_sample(input sample_t s);
    for (int i = WIN - 1; i > 0; i--) begin
      history[i] = history[i-1];
    end
    history[0] = s;
    expected_q.push_back(window_median());
    frame_count++;
    // end of frame, the DUT flushes back to zero padding
    if (frame_count == FRAME_LEN) begin
      frame_count = 0;
      flush_left  = WIN;
      clear_history();
    end
  endtask

  task automatic check_outputs();
    sample_t exp_val;
    assert (busy == (flush_left > 0)) else begin
      $display("FAILED at %0t: busy is %0b, expected %0b", $time, busy, flush_left > 0);
      abort_run();
    end
    if (out_valid) begin
      assert (expected_q.size() > 0) else begin
        $display("FAILED at %0t: out_valid with no sample in flight", $time);
        abort_run();
      end
      exp_val = expected_q.pop_front();
      assert (dout == exp_val) else begin
        $display("FAILED at %0t: dout is %0d, expected median %0d", $time, dout, exp_val);
        abort_run();
      end
    end
  endtask

  // check, then drive the next cycle on the falling edge
  task automatic drive_cycle(input logic en, input sample_t data, output logic taken);
    @(negedge CLK);
    check_outputs();
    if (flush_left > 0) begin
      flush_left--;
    end
    in_en = en;
    din   = data;
    // busy is stable here until the next rising edge
    taken = en && !busy;
    if (taken) begin
      record_sample(data);
    end
  endtask

  // random samples until count of them were accepted
  task automatic feed_random(input int count, input logic with_gaps);
    int      accepted;
    logic    en;
    logic    taken;
    sample_t data;
    accepted = 0;
    while (accepted < count) begin
      en   = with_gaps ? (($random(seed) & 3) != 0) : 1'b1;
      data = sample_t'($random(seed));
      drive_cycle(en, data, taken);
      if (taken) begin
        accepted++;
      end
    end
  endtask

  // bound checker failures end the run too
  always @(negedge CLK) begin
    if (lmfe_median_i.lmfe_median_sva_i.fail_count != 0) begin
      $display("A bound timing assertion failed at time %0t", $time);
      abort_run();
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("The watchdog expired at time %0t before the run finished", $time);
    abort_run();
  end

  initial begin
    logic taken;
    seed         = 46947;
    RST          = 1'b1;
    in_en        = 1'b0;
    din          = '0;
    frame_count  = 0;
    flush_left   = 0;
    clear_history();
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    assert (!busy && !out_valid && dout == '0) else begin
      $display("FAILED at %0t: outputs not idle after reset", $time);
      abort_run();
    end

    // zero padding shows in the first medians
    for (int i = 0; i < WIN; i++) begin
      drive_cycle(1'b1, sample_t'(200), taken);
    end
    // eighth 200 deletes a 200, an equal pair
    drive_cycle(1'b1, sample_t'(200), taken);
    feed_random(30, 1'b0);
    feed_random(FRAME_LEN - WIN - 1 - 30, 1'b1);

    // in_en held high through the flush, then a full frame
    feed_random(FRAME_LEN, 1'b0);

    // gapped stream from a cleared window
    feed_random(FRAME_LEN, 1'b1);

    // last flush and the results still in flight, then quiet cycles
    repeat (WIN + 3) begin
      drive_cycle(1'b0, '0, taken);
    end

    assert (expected_q.size() == 0) else begin
      $display("FAILED at %0t: %0d expected results never appeared", $time,
               expected_q.size());
      abort_run();
    end

    if (lmfe_median_i.lmfe_median_sva_i.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("The bound timing assertions reported errors");
      abort_run();
    end
  end

endmodule

// File: lmfe_median.f
hdl/lmfe_cfg_pkg.sv
hdl/lmfe_ctrl_pkg.sv
hdl/rank_cell.sv
hdl/rank_sorter.sv
hdl/window_shift.sv
hdl/frame_counter.sv
hdl/median_ctrl.sv
hdl/lmfe_median.sv
bench/lmfe_median_sva.sv
bench/lmfe_median_tb.sv

// File: Bender.yml
package:
  name: lmfe_median

sources:
  - hdl/lmfe_cfg_pkg.sv
  - hdl/lmfe_ctrl_pkg.sv
  - hdl/rank_cell.sv
  - hdl/rank_sorter.sv
  - hdl/window_shift.sv
  - hdl/frame_counter.sv
  - hdl/median_ctrl.sv
  - hdl/lmfe_median.sv
  - target: simulation
    files:
      - bench/lmfe_median_sva.sv
      - bench/lmfe_median_tb.sv
